// File: src/rvIsaPkg.sv
package rvIsaPkg;

    localparam int xlen = 32;
    localparam int regNameW = 5;

    // major opcodes
    localparam logic [6:0] opcOp    = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLui   = 7'b0110111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // alt form selects SUB and SRA/SRAI
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
    } rvInstr_u;

endpackage

// File: src/oooPkg.sv
package oooPkg;

    localparam int rsDepth = 8;
    localparam int tagW = $clog2(rsDepth);

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        // LUI, result is operand B
        aluPassB
    } aluOp_e;

    // lowest set bit wins, used for entry allocation and issue
    function automatic logic [tagW-1:0] lowestSet(input logic [rsDepth-1:0] mask);
        logic [tagW-1:0] idx;
        idx = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = tagW'(i);
            end
        end
        return idx;
    endfunction

endpackage

// File: src/instrDecoder.sv
module instrDecoder (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    output logic                          instrReady,
    input  rvIsaPkg::rvInstr_u            instr,
    output logic                          decValid,
    input  logic                          decReady,
    output oooPkg::aluOp_e                decOp,
    output logic [rvIsaPkg::regNameW-1:0] decRs1,
    output logic [rvIsaPkg::regNameW-1:0] decRs2,
    output logic [rvIsaPkg::regNameW-1:0] decRd,
    output logic                          decUseRs1,
    output logic                          decUseRs2,
    output logic [rvIsaPkg::xlen-1:0]     decImm
);
    import rvIsaPkg::*;
    import oooPkg::*;

    logic            accept;
    logic            legal;
    logic            altFn;
    logic            useRs1;
    logic            useRs2;
    aluOp_e          op;
    logic [xlen-1:0] imm;

    // holding register empties or drains this cycle
    assign instrReady = !decValid || decReady;
    assign accept = instrValid && instrReady;
    assign altFn = instr.rType.funct7 == f7Alt;

    always_comb begin
        legal = 1'b1;
        useRs1 = 1'b1;
        useRs2 = 1'b0;
        imm = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
        case (instr.rType.funct3)
            f3AddSub: op = (altFn && instr.rType.opcode == opcOp) ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = altFn ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            default:  op = aluAnd;
        endcase
        case (instr.rType.opcode)
            opcOp: begin
                useRs2 = 1'b1;
            end
            opcOpImm: begin
                // shamt sits in the low immediate bits
                if (instr.iType.funct3 == f3Sll || instr.iType.funct3 == f3SrlSra) begin
                    imm = xlen'(instr.iType.imm12[4:0]);
                end
            end
            opcLui: begin
                op = aluPassB;
                useRs1 = 1'b0;
                imm = {instr.uType.imm20, 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (accept) begin
            // illegal words are swallowed here
            decValid <= legal;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decOp <= op;
            decRs1 <= instr.rType.rs1;
            decRs2 <= instr.rType.rs2;
            decRd <= instr.rType.rd;
            decUseRs1 <= useRs1;
            decUseRs2 <= useRs2;
            decImm <= imm;
        end
    end

endmodule

// File: src/regStatusFile.sv
module regStatusFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [rvIsaPkg::regNameW-1:0] rs1Name,
    input  logic [rvIsaPkg::regNameW-1:0] rs2Name,
    output logic                          rs1Busy,
    output logic                          rs2Busy,
    output logic [oooPkg::tagW-1:0]       rs1Tag,
    output logic [oooPkg::tagW-1:0]       rs2Tag,
    output logic [rvIsaPkg::xlen-1:0]     rs1Data,
    output logic [rvIsaPkg::xlen-1:0]     rs2Data,
    input  logic                          renameEn,
    input  logic [rvIsaPkg::regNameW-1:0] renameName,
    input  logic [oooPkg::tagW-1:0]       renameTag,
    input  logic                          cdbValid,
    input  logic [oooPkg::tagW-1:0]       cdbTag,
    input  logic [rvIsaPkg::xlen-1:0]     cdbData,
    input  logic [rvIsaPkg::regNameW-1:0] archRdName,
    output logic [rvIsaPkg::xlen-1:0]     archRdData,
    output logic                          archRdBusy
);
    import rvIsaPkg::*;
    import oooPkg::*;

    logic [xlen-1:0] regData [32];
    logic [tagW-1:0] regTag [32];
    logic [31:0]     regBusy;
    logic            staleHit;

    // x0 is never written, so it reads zero and idle
    assign rs1Busy = regBusy[rs1Name];
    assign rs1Tag = regTag[rs1Name];
    assign rs1Data = regData[rs1Name];
    assign rs2Busy = regBusy[rs2Name];
    assign rs2Tag = regTag[rs2Name];
    assign rs2Data = regData[rs2Name];
    assign archRdData = regData[archRdName];
    assign archRdBusy = regBusy[archRdName];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regData[i] <= '0;
                regTag[i] <= '0;
            end
            regBusy <= '0;
        end else begin
            for (int i = 1; i < 32; i++) begin
                // new producer overrides a retiring one
                if (renameEn && renameName == regNameW'(i)) begin
                    regBusy[i] <= 1'b1;
                    regTag[i] <= renameTag;
                end else if (cdbValid && regBusy[i] && regTag[i] == cdbTag) begin
                    regBusy[i] <= 1'b0;
                    regData[i] <= cdbData;
                end
            end
        end
    end

    // a register still waiting on the tag being handed out again
    always_comb begin
        staleHit = 1'b0;
        for (int i = 1; i < 32; i++) begin
            if (regBusy[i] && regTag[i] == renameTag && !(cdbValid && cdbTag == renameTag)) begin
                staleHit = 1'b1;
            end
        end
    end

    tagReuse: assert property (@(posedge clk) disable iff (!rstN) renameEn |-> !staleHit);

endmodule

// File: src/dispatchUnit.sv
module dispatchUnit (
    input  logic                          decValid,
    output logic                          decReady,
    input  oooPkg::aluOp_e                decOp,
    input  logic [rvIsaPkg::regNameW-1:0] decRs1,
    input  logic [rvIsaPkg::regNameW-1:0] decRs2,
    input  logic                          decUseRs1,
    input  logic                          decUseRs2,
    input  logic [rvIsaPkg::regNameW-1:0] decRd,
    input  logic [rvIsaPkg::xlen-1:0]     decImm,
    output logic [rvIsaPkg::regNameW-1:0] rs1Name,
    output logic [rvIsaPkg::regNameW-1:0] rs2Name,
    input  logic                          rs1Busy,
    input  logic [oooPkg::tagW-1:0]       rs1Tag,
    input  logic [rvIsaPkg::xlen-1:0]     rs1Data,
    input  logic                          rs2Busy,
    input  logic [oooPkg::tagW-1:0]       rs2Tag,
    input  logic [rvIsaPkg::xlen-1:0]     rs2Data,
    output logic                          renameEn,
    output logic [rvIsaPkg::regNameW-1:0] renameName,
    output logic [oooPkg::tagW-1:0]       renameTag,
    input  logic [oooPkg::rsDepth-1:0]    freeMask,
    output logic                          allocEn,
    output logic [oooPkg::tagW-1:0]       allocIdx,
    output oooPkg::aluOp_e                allocOp,
    output logic                          allocReadyA,
    output logic [oooPkg::tagW-1:0]       allocTagA,
    output logic [rvIsaPkg::xlen-1:0]     allocDataA,
    output logic                          allocReadyB,
    output logic [oooPkg::tagW-1:0]       allocTagB,
    output logic [rvIsaPkg::xlen-1:0]     allocDataB,
    input  logic                          cdbValid,
    input  logic [oooPkg::tagW-1:0]       cdbTag,
    input  logic [rvIsaPkg::xlen-1:0]     cdbData
);
    import oooPkg::*;

    // not needed, already written, or arriving on the CDB right now
    function automatic logic opReady(input logic needed, input logic busy,
                                     input logic [tagW-1:0] tag);
        return !needed || !busy || (cdbValid && cdbTag == tag);
    endfunction

    assign decReady = |freeMask;
    assign allocEn = decValid && decReady;
    // free-tag table as a priority pick
    assign allocIdx = lowestSet(freeMask);
    assign allocOp = decOp;

    assign rs1Name = decRs1;
    assign rs2Name = decRs2;

    // x0 renames are dropped by the register file
    assign renameEn = allocEn;
    assign renameName = decRd;
    assign renameTag = allocIdx;

    assign allocReadyA = opReady(decUseRs1, rs1Busy, rs1Tag);
    assign allocTagA = rs1Tag;
    assign allocDataA = !decUseRs1 ? '0 : (rs1Busy ? cdbData : rs1Data);

    // immediate forms put the immediate in B
    assign allocReadyB = opReady(decUseRs2, rs2Busy, rs2Tag);
    assign allocTagB = rs2Tag;
    assign allocDataB = !decUseRs2 ? decImm : (rs2Busy ? cdbData : rs2Data);

    always_comb begin
        if (allocEn) begin
            allocFree: assert (freeMask[allocIdx]);
        end
    end

endmodule

// File: src/aluStation.sv
module aluStation (
    input  logic                       clk,
    input  logic                       rstN,
    output logic [oooPkg::rsDepth-1:0] freeMask,
    input  logic                       allocEn,
    input  logic [oooPkg::tagW-1:0]    allocIdx,
    input  oooPkg::aluOp_e             allocOp,
    input  logic                       allocReadyA,
    input  logic [oooPkg::tagW-1:0]    allocTagA,
    input  logic [rvIsaPkg::xlen-1:0]  allocDataA,
    input  logic                       allocReadyB,
    input  logic [oooPkg::tagW-1:0]    allocTagB,
    input  logic [rvIsaPkg::xlen-1:0]  allocDataB,
    output logic                       cdbValid,
    output logic [oooPkg::tagW-1:0]    cdbTag,
    output logic [rvIsaPkg::xlen-1:0]  cdbData
);
    import rvIsaPkg::*;
    import oooPkg::*;

    logic [rsDepth-1:0] entBusy;
    logic [rsDepth-1:0] entReadyA;
    logic [rsDepth-1:0] entReadyB;
    aluOp_e             entOp [rsDepth];
    logic [tagW-1:0]    entTagA [rsDepth];
    logic [tagW-1:0]    entTagB [rsDepth];
    logic [xlen-1:0]    entA [rsDepth];
    logic [xlen-1:0]    entB [rsDepth];

    logic [rsDepth-1:0] issueMask;
    logic               issueEn;
    logic [tagW-1:0]    issueIdx;
    logic [xlen-1:0]    opA;
    logic [xlen-1:0]    opB;
    logic [xlen-1:0]    aluRes;

    assign freeMask = ~entBusy;
    assign issueMask = entBusy & entReadyA & entReadyB;
    assign issueEn = |issueMask;
    assign issueIdx = lowestSet(issueMask);
    assign opA = entA[issueIdx];
    assign opB = entB[issueIdx];

    always_comb begin
        case (entOp[issueIdx])
            aluAdd:   aluRes = opA + opB;
            aluSub:   aluRes = opA - opB;
            aluSll:   aluRes = opA << opB[4:0];
            aluSlt:   aluRes = xlen'($signed(opA) < $signed(opB));
            aluSltu:  aluRes = xlen'(opA < opB);
            aluXor:   aluRes = opA ^ opB;
            aluSrl:   aluRes = opA >> opB[4:0];
            aluSra:   aluRes = $signed(opA) >>> opB[4:0];
            aluOr:    aluRes = opA | opB;
            aluAnd:   aluRes = opA & opB;
            aluPassB: aluRes = opB;
            default:  aluRes = '0;
        endcase
    end

    // entry frees as it issues
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entBusy <= '0;
        end else begin
            if (issueEn) begin
                entBusy[issueIdx] <= 1'b0;
            end
            if (allocEn) begin
                entBusy[allocIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // snoop the registered broadcast
        for (int i = 0; i < rsDepth; i++) begin
            if (cdbValid && !entReadyA[i] && entTagA[i] == cdbTag) begin
                entReadyA[i] <= 1'b1;
                entA[i] <= cdbData;
            end
            if (cdbValid && !entReadyB[i] && entTagB[i] == cdbTag) begin
                entReadyB[i] <= 1'b1;
                entB[i] <= cdbData;
            end
        end
        if (allocEn) begin
            entOp[allocIdx] <= allocOp;
            entReadyA[allocIdx] <= allocReadyA;
            entTagA[allocIdx] <= allocTagA;
            entA[allocIdx] <= allocDataA;
            entReadyB[allocIdx] <= allocReadyB;
            entTagB[allocIdx] <= allocTagB;
            entB[allocIdx] <= allocDataB;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cdbValid <= 1'b0;
        end else begin
            cdbValid <= issueEn;
        end
    end

    // entry index doubles as the result tag
    always_ff @(posedge clk) begin
        if (issueEn) begin
            cdbTag <= issueIdx;
            cdbData <= aluRes;
        end
    end

    issueBusy: assert property (@(posedge clk) disable iff (!rstN)
        issueEn |-> entBusy[issueIdx] && !(allocEn && allocIdx == issueIdx));

endmodule

// File: src/dispatchCore.sv
module dispatchCore (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    output logic                          instrReady,
    input  rvIsaPkg::rvInstr_u            instr,
    output logic                          cdbValid,
    output logic [oooPkg::tagW-1:0]       cdbTag,
    output logic [rvIsaPkg::xlen-1:0]     cdbData,
    input  logic [rvIsaPkg::regNameW-1:0] archRdName,
    output logic [rvIsaPkg::xlen-1:0]     archRdData,
    output logic                          archRdBusy
);
    import rvIsaPkg::*;
    import oooPkg::*;

    logic                decValid;
    logic                decReady;
    aluOp_e              decOp;
    logic [regNameW-1:0] decRs1;
    logic [regNameW-1:0] decRs2;
    logic [regNameW-1:0] decRd;
    logic                decUseRs1;
    logic                decUseRs2;
    logic [xlen-1:0]     decImm;

    logic [regNameW-1:0] rs1Name;
    logic [regNameW-1:0] rs2Name;
    logic                rs1Busy;
    logic                rs2Busy;
    logic [tagW-1:0]     rs1Tag;
    logic [tagW-1:0]     rs2Tag;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic                renameEn;
    logic [regNameW-1:0] renameName;
    logic [tagW-1:0]     renameTag;

    logic [rsDepth-1:0]  freeMask;
    logic                allocEn;
    logic [tagW-1:0]     allocIdx;
    aluOp_e              allocOp;
    logic                allocReadyA;
    logic [tagW-1:0]     allocTagA;
    logic [xlen-1:0]     allocDataA;
    logic                allocReadyB;
    logic [tagW-1:0]     allocTagB;
    logic [xlen-1:0]     allocDataB;

    instrDecoder i_instrDecoder (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instr(instr),
        .decValid(decValid),
        .decReady(decReady),
        .decOp(decOp),
        .decRs1(decRs1),
        .decRs2(decRs2),
        .decRd(decRd),
        .decUseRs1(decUseRs1),
        .decUseRs2(decUseRs2),
        .decImm(decImm)
    );

    dispatchUnit i_dispatchUnit (
        .decValid(decValid),
        .decReady(decReady),
        .decOp(decOp),
        .decRs1(decRs1),
        .decRs2(decRs2),
        .decUseRs1(decUseRs1),
        .decUseRs2(decUseRs2),
        .decRd(decRd),
        .decImm(decImm),
        .rs1Name(rs1Name),
        .rs2Name(rs2Name),
        .rs1Busy(rs1Busy),
        .rs1Tag(rs1Tag),
        .rs1Data(rs1Data),
        .rs2Busy(rs2Busy),
        .rs2Tag(rs2Tag),
        .rs2Data(rs2Data),
        .renameEn(renameEn),
        .renameName(renameName),
        .renameTag(renameTag),
        .freeMask(freeMask),
        .allocEn(allocEn),
        .allocIdx(allocIdx),
        .allocOp(allocOp),
        .allocReadyA(allocReadyA),
        .allocTagA(allocTagA),
        .allocDataA(allocDataA),
        .allocReadyB(allocReadyB),
        .allocTagB(allocTagB),
        .allocDataB(allocDataB),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

    aluStation i_aluStation (
        .clk(clk),
        .rstN(rstN),
        .freeMask(freeMask),
        .allocEn(allocEn),
        .allocIdx(allocIdx),
        .allocOp(allocOp),
        .allocReadyA(allocReadyA),
        .allocTagA(allocTagA),
        .allocDataA(allocDataA),
        .allocReadyB(allocReadyB),
        .allocTagB(allocTagB),
        .allocDataB(allocDataB),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

    regStatusFile i_regStatusFile (
        .clk(clk),
        .rstN(rstN),
        .rs1Name(rs1Name),
        .rs2Name(rs2Name),
        .rs1Busy(rs1Busy),
        .rs2Busy(rs2Busy),
        .rs1Tag(rs1Tag),
        .rs2Tag(rs2Tag),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .renameEn(renameEn),
        .renameName(renameName),
        .renameTag(renameTag),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData),
        .archRdName(archRdName),
        .archRdData(archRdData),
        .archRdBusy(archRdBusy)
    );

endmodule

// File: bench/dispatchCoreTb.sv
module dispatchCoreTb;
    import rvIsaPkg::*;
    import oooPkg::*;

    localparam int stallLimit = 200;
    localparam int drainLimit = 400;

    logic                clk;
    logic                rstN;
    logic                instrValid;
    logic                instrReady;
    rvInstr_u            instr;
    logic                cdbValid;
    logic [tagW-1:0]     cdbTag;
    logic [xlen-1:0]     cdbData;
    logic [regNameW-1:0] archRdName;
    logic [xlen-1:0]     archRdData;
    logic                archRdBusy;

    integer              seed;
    logic [xlen-1:0]     archModel [32];
    // results still expected on the CDB, in program order
    logic [xlen-1:0]     expData [$];
    logic [regNameW-1:0] expRd [$];
    // station entry holding each result, -1 until it dispatches
    int                  expTag [$];
    logic [rsDepth-1:0]  tagBusy;
    bit                  decHeld;
    bit                  sawStall;

    dispatchCore i_dispatchCore (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instr(instr),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData),
        .archRdName(archRdName),
        .archRdData(archRdData),
        .archRdBusy(archRdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopWithFail(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic errorAt(input string msg);
        stopWithFail($sformatf("Error at time %0t: %s", $time, msg));
    endtask

    // lowest unused station entry
    function automatic logic [tagW-1:0] firstFree(input logic [rsDepth-1:0] used);
        logic [tagW-1:0] idx;
        bit              found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < rsDepth; i++) begin
            if (!found && !used[i]) begin
                idx = tagW'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic checkCdb(input logic [tagW-1:0] tag, input logic [xlen-1:0] data);
        int hit;
        hit = -1;
        foreach (expTag[i]) begin
            if (expTag[i] == int'(tag)) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            errorAt($sformatf("CDB tag %0d data %h belongs to no dispatched word",
                              tag, data));
        end else if (expData[hit] !== data) begin
            errorAt($sformatf("CDB tag %0d data %h, expected %h for x%0d",
                              tag, data, expData[hit], expRd[hit]));
        end else begin
            expData.delete(hit);
            expRd.delete(hit);
            expTag.delete(hit);
            tagBusy[tag] = 1'b0;
        end
    endtask

    // every falling edge passes through here, so no broadcast is missed
    task automatic nextCycle();
        logic [tagW-1:0] t;
        @(negedge clk);
        if (cdbValid) begin
            checkCdb(cdbTag, cdbData);
        end
        // held word enters the station at the coming edge
        if (decHeld && instrReady) begin
            if (&tagBusy) begin
                errorAt("decoded word dispatched while every station entry is in use");
            end else begin
                t = firstFree(tagBusy);
                expTag[expTag.size() - 1] = int'(t);
                tagBusy[t] = 1'b1;
                decHeld = 1'b0;
            end
        end
    endtask

    task automatic checkReg(input logic [regNameW-1:0] name, input logic [xlen-1:0] value);
        archRdName = name;
        nextCycle();
        if (archRdBusy) begin
            errorAt($sformatf("x%0d still busy", name));
        end else if (archRdData !== value) begin
            errorAt($sformatf("x%0d reads %h, expected %h", name, archRdData, value));
        end
    endtask

    function automatic rvInstr_u makeOp(input logic [2:0] f3, input logic alt,
                                        input logic [regNameW-1:0] rd,
                                        input logic [regNameW-1:0] rs1,
                                        input logic [regNameW-1:0] rs2);
        rvInstr_u w;
        w.rType.opcode = opcOp;
        w.rType.funct3 = f3;
        w.rType.rd = rd;
        w.rType.rs1 = rs1;
        w.rType.rs2 = rs2;
        w.rType.funct7 = (alt && (f3 == f3AddSub || f3 == f3SrlSra)) ? f7Alt : f7Base;
        return w;
    endfunction

    function automatic rvInstr_u makeImm(input logic [2:0] f3, input logic alt,
                                         input logic [regNameW-1:0] rd,
                                         input logic [regNameW-1:0] rs1,
                                         input logic [11:0] imm);
        rvInstr_u w;
        w.iType.opcode = opcOpImm;
        w.iType.funct3 = f3;
        w.iType.rd = rd;
        w.iType.rs1 = rs1;
        w.iType.imm12 = imm;
        // shifts only carry a shamt and the SRAI bit
        if (f3 == f3Sll) begin
            w.iType.imm12 = {f7Base, imm[4:0]};
        end else if (f3 == f3SrlSra) begin
            w.iType.imm12 = {alt ? f7Alt : f7Base, imm[4:0]};
        end
        return w;
    endfunction

    // sequential ISA model, run as the DUT takes the word
    task automatic execute(input rvInstr_u w);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic [4:0]      shamt;
        logic            alt;
        a = archModel[w.rType.rs1];
        if (w.rType.opcode == opcOp) begin
            b = archModel[w.rType.rs2];
        end else begin
            b = {{20{w.iType.imm12[11]}}, w.iType.imm12};
        end
        shamt = b[4:0];
        alt = w.rType.funct7[5];
        case (w.rType.funct3)
            f3AddSub: res = (alt && w.rType.opcode == opcOp) ? a - b : a + b;
            f3Sll:    res = a << shamt;
            f3Slt:    res = {31'b0, $signed(a) < $signed(b)};
            f3Sltu:   res = {31'b0, a < b};
            f3Xor:    res = a ^ b;
            f3SrlSra: begin
                if (alt) begin
                    res = $signed(a) >>> shamt;
                end else begin
                    res = a >> shamt;
                end
            end
            f3Or:     res = a | b;
            default:  res = a & b;
        endcase
        if (w.uType.opcode == opcLui) begin
            res = {w.uType.imm20, 12'b0};
        end
        if (w.rType.opcode inside {opcOp, opcOpImm, opcLui}) begin
            expData.push_back(res);
            expRd.push_back(w.rType.rd);
            expTag.push_back(-1);
            decHeld = 1'b1;
            if (w.rType.rd != '0) begin
                archModel[w.rType.rd] = res;
            end
        end
    endtask

    task automatic sendWord(input rvInstr_u w, input int gap);
        int held;
        held = 0;
        for (int i = 0; i < gap; i++) begin
            nextCycle();
            instrValid = 1'b0;
            instr = rvInstr_u'($random(seed));
        end
        nextCycle();
        instrValid = 1'b1;
        instr = w;
        while (!instrReady) begin
            sawStall = 1'b1;
            if (held == stallLimit) begin
                stopWithFail($sformatf("timed out: instrReady stayed low for %0d cycles", held));
            end else begin
                held++;
                nextCycle();
            end
        end
        // taken at the coming rising edge
        execute(w);
    endtask

    task automatic pickWord(output rvInstr_u w);
        logic [31:0] r;
        logic [31:0] v;
        logic [6:0]  opc;
        r = $random(seed);
        v = $random(seed);
        if (r[3:0] == 4'd0) begin
            case (r[18:16])
                3'd0:    opc = 7'b0000011;
                3'd1:    opc = 7'b0100011;
                3'd2:    opc = 7'b1100011;
                3'd3:    opc = 7'b1101111;
                3'd4:    opc = 7'b0010111;
                3'd5:    opc = 7'b1110011;
                3'd6:    opc = 7'b1100111;
                default: opc = 7'b0001111;
            endcase
            w = rvInstr_u'(v);
            w.rType.opcode = opc;
        end else if (r[3:0] < 4'd7) begin
            w = makeOp(r[12:10], r[13], {3'b0, r[5:4]}, {3'b0, r[7:6]}, {3'b0, r[9:8]});
        end else if (r[3:0] < 4'd13) begin
            w = makeImm(r[12:10], r[13], {3'b0, r[5:4]}, {3'b0, r[7:6]}, v[11:0]);
        end else begin
            w.uType.opcode = opcLui;
            w.uType.rd = {3'b0, r[5:4]};
            w.uType.imm20 = v[31:12];
        end
    endtask

    task automatic runRandom(input int count);
        rvInstr_u    w;
        logic [31:0] g;
        for (int n = 0; n < count; n++) begin
            pickWord(w);
            g = $random(seed);
            sendWord(w, (g[2:0] == 3'd0) ? int'(g[4:3]) + 1 : 0);
        end
    endtask

    // long chain on x1, then a pile of words waiting on its tail
    task automatic runBurst();
        rvInstr_u    w;
        logic [31:0] v;
        sawStall = 1'b0;
        for (int i = 0; i < 10; i++) begin
            v = $random(seed);
            sendWord(makeImm(f3AddSub, 1'b0, 5'd1, 5'd1, v[11:0]), 0);
        end
        for (int i = 0; i < 12; i++) begin
            v = $random(seed);
            w = makeOp(v[2:0], v[3], v[4] ? 5'd3 : 5'd2, 5'd1, v[5] ? 5'd1 : 5'd0);
            sendWord(w, 0);
        end
        if (!sawStall) begin
            stopWithFail("the station never filled during the dependent burst");
        end
    endtask

    initial begin
        int waitCycles;
        seed = 32'hc2f1_52c4;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        archRdName = '0;
        tagBusy = '0;
        decHeld = 1'b0;
        sawStall = 1'b0;
        waitCycles = 0;
        for (int i = 0; i < 32; i++) begin
            archModel[i] = '0;
        end
        repeat (16) @(negedge clk);
        rstN = 1'b1;

        // idle after reset
        for (int i = 0; i < 32; i++) begin
            if (!instrReady) begin
                errorAt("instrReady low while idle after reset");
            end else begin
                checkReg(5'(i), '0);
            end
        end

        runRandom(300);
        runBurst();
        runRandom(100);

        nextCycle();
        instrValid = 1'b0;
        while (expData.size() != 0) begin
            if (waitCycles == drainLimit) begin
                stopWithFail($sformatf("timed out draining, %0d results never broadcast",
                                       expData.size()));
            end else begin
                waitCycles++;
                nextCycle();
            end
        end
        // nothing more may appear once drained
        repeat (8) nextCycle();
        for (int i = 0; i < 32; i++) begin
            checkReg(5'(i), (i == 0) ? '0 : archModel[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: filelist.f
src/rvIsaPkg.sv
src/oooPkg.sv
src/instrDecoder.sv
src/regStatusFile.sv
src/dispatchUnit.sv
src/aluStation.sv
src/dispatchCore.sv
bench/dispatchCoreTb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := dispatchCoreTb
FILELIST := filelist.f
BUILDDIR := obj_dir

SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIMBIN   := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o V$(TOP)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(BUILDDIR)
